/* hw/csr_pkg.sv */
// shared sizes and CSR address map
// operation encoding for CSR instructions
// request, response and interrupt bus structs

package csr_pkg;

    // datapath and core sizing
    localparam int xlen          = 32;
    localparam int num_lanes     = 4;
    localparam int num_warps     = 4;
    localparam int nw_bits       = $clog2(num_warps);
    localparam int nt_bits       = $clog2(num_lanes);
    localparam int core_id       = 1;
    localparam int csr_addr_bits = 12;
    localparam int num_irq       = 4;

    // CSR address map
    localparam logic [csr_addr_bits-1:0] csr_fcsr      = 12'h003;
    localparam logic [csr_addr_bits-1:0] csr_mscratch  = 12'h340;
    localparam logic [csr_addr_bits-1:0] csr_mcycle    = 12'hB00;
    localparam logic [csr_addr_bits-1:0] csr_mhartid   = 12'hF14;
    localparam logic [csr_addr_bits-1:0] csr_thread_id = 12'hCC0;

    // interrupt controller window, end is exclusive
    localparam logic [csr_addr_bits-1:0] itr_ctrl_begin = 12'h7C0;
    localparam logic [csr_addr_bits-1:0] itr_ctrl_end   = 12'h7C2;

    // CSR instruction flavours
    typedef enum logic [1:0] {
        csr_rw = 2'd0,
        csr_rs = 2'd1,
        csr_rc = 2'd2
    } csr_op_e;

    // issue stage to CSR unit
    typedef struct packed {
        logic [nw_bits-1:0]       wid;
        logic [num_lanes-1:0]     tmask;
        logic [xlen-1:0]          pc;
        logic [4:0]               rd;
        logic                     wb;
        csr_op_e                  op;
        logic                     use_imm;
        logic [csr_addr_bits-1:0] addr;
        logic [4:0]               imm;
        // lane 0 only
        logic [xlen-1:0]          rs1;
    } csr_req_t;

    // CSR unit to commit stage
    typedef struct packed {
        logic [nw_bits-1:0]                 wid;
        logic [num_lanes-1:0]               tmask;
        logic [xlen-1:0]                    pc;
        logic [4:0]                         rd;
        logic                               wb;
        logic [num_lanes-1:0][xlen-1:0]     data;
    } csr_rsp_t;

    // write port into the interrupt controller
    typedef struct packed {
        logic            write_enable;
        // low address bit picks pending over enable
        logic            sel_pending;
        logic [xlen-1:0] write_data;
    } itr_bus_t;

endpackage

/* hw/csr_data.sv */
// CSR storage for mscratch, fcsr and the mcycle counter
// combinational read port split into rw and ro words
// single write port, read-only and unknown addresses ignored

module csr_data import csr_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,

    input  logic [csr_addr_bits-1:0] read_addr,
    output logic [xlen-1:0]          read_data_ro,
    output logic [xlen-1:0]          read_data_rw,

    input  logic                     write_enable,
    input  logic [csr_addr_bits-1:0] write_addr,
    input  logic [xlen-1:0]          write_data
);

    logic [xlen-1:0] mscratch_q;
    // floating point control, only the low byte exists
    logic [7:0]      fcsr_q;
    logic [xlen-1:0] mcycle_q;

    // register updates
    always_ff @(posedge clk) begin
        if (reset) begin
            mscratch_q <= '0;
            fcsr_q     <= '0;
            mcycle_q   <= '0;
        end else begin
            // free running
            mcycle_q <= mcycle_q + xlen'(1);

            if (write_enable) begin
                case (write_addr)
                    csr_mscratch: begin
                        mscratch_q <= write_data;
                    end
                    csr_fcsr: begin
                        fcsr_q <= write_data[7:0];
                    end
                    default: begin
                        // mcycle and unknown addresses drop the write
                    end
                endcase
            end
        end
    end

    // read decode
    always_comb begin
        read_data_rw = '0;
        read_data_ro = '0;
        case (read_addr)
            csr_mscratch: begin
                read_data_rw = mscratch_q;
            end
            csr_fcsr: begin
                read_data_rw = xlen'(fcsr_q);
            end
            csr_mcycle: begin
                read_data_ro = mcycle_q;
            end
            default: begin
                // unknown reads as zero on both ports
            end
        endcase
    end

endmodule

/* hw/itr_ctrl.sv */
// interrupt enable and sticky pending registers
// external irq capture and registered interrupt request

module itr_ctrl import csr_pkg::*; (
    input  logic               clk,
    input  logic               reset,

    input  logic [num_irq-1:0] irq_lines,
    input  itr_bus_t           bus,

    output logic [num_irq-1:0] enable_q,
    output logic [num_irq-1:0] pending_q,
    output logic               itr_req
);

    logic               wr_enable;
    logic               wr_pending;
    logic [num_irq-1:0] wr_bits;

    assign wr_enable  = bus.write_enable && !bus.sel_pending;
    assign wr_pending = bus.write_enable && bus.sel_pending;
    // only the low bits map onto irq lines
    assign wr_bits    = bus.write_data[num_irq-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            enable_q <= '0;
        end else if (wr_enable) begin
            enable_q <= wr_bits;
        end
    end

    // pending bits stick until software clears them
    // a line still high during the write wins over the clear
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= '0;
        end else if (wr_pending) begin
            pending_q <= wr_bits | irq_lines;
        end else begin
            pending_q <= pending_q | irq_lines;
        end
    end

    // request follows the register state one edge later
    always_ff @(posedge clk) begin
        if (reset) begin
            itr_req <= 1'b0;
        end else begin
            itr_req <= |(pending_q & enable_q);
        end
    end

endmodule

/* hw/rsp_buffer.sv */
// two entry elastic buffer for CSR responses
// valid/ready on both sides with registered outputs

module rsp_buffer import csr_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  logic     valid_in,
    output logic     ready_in,
    input  csr_rsp_t data_in,

    output logic     valid_out,
    output csr_rsp_t data_out,
    input  logic     ready_out
);

    // slot0 is the head and drives the output
    csr_rsp_t   slot0;
    csr_rsp_t   slot1;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign ready_in  = (count != 2'd2);
    assign valid_out = (count != 2'd0);
    assign data_out  = slot0;

    assign push = valid_in && ready_in;
    assign pop  = valid_out && ready_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= 2'd0;
        end else begin
            count <= count + 2'(push) - 2'(pop);
        end
    end

    // payload moves only
    always_ff @(posedge clk) begin
        case (count)
            2'd0: begin
                if (push) begin
                    slot0 <= data_in;
                end
            end
            2'd1: begin
                if (push && pop) begin
                    slot0 <= data_in;
                end else if (push) begin
                    slot1 <= data_in;
                end
            end
            default: begin
                // full, advance the second entry
                if (pop) begin
                    slot0 <= slot1;
                end
            end
        endcase
    end

endmodule

/* hw/csr_unit.sv */
// CSR execution unit
// request gating on the scheduler, address decode and per-lane ids
// read-modify-write merge, warp unlock and response formation

module csr_unit import csr_pkg::*; (
    input  logic               clk,
    input  logic               reset,

    input  logic               req_valid,
    input  csr_req_t           req,
    output logic               req_ready,
    input  logic               no_pending,

    output logic               rsp_valid,
    output csr_rsp_t           rsp,
    input  logic               rsp_ready,

    output logic               unlock,
    output logic [nw_bits-1:0] unlock_wid,

    output itr_bus_t           itr_bus,
    input  logic [num_irq-1:0] itr_enable,
    input  logic [num_irq-1:0] itr_pending
);

    logic                           buf_ready;
    logic                           req_gated;
    logic                           req_fire;
    logic                           itr_sel;
    logic [xlen-1:0]                read_data_ro;
    logic [xlen-1:0]                read_data_rw;
    logic [xlen-1:0]                itr_word;
    logic [xlen-1:0]                old_value;
    logic [xlen-1:0]                src_value;
    logic [xlen-1:0]                new_value;
    logic                           wr_allowed;
    logic [num_lanes-1:0][xlen-1:0] hart_id;
    logic [num_lanes-1:0][xlen-1:0] lane_data;
    csr_rsp_t                       rsp_in;

    // hold the warp until all its earlier instructions retire
    assign req_gated = req_valid && no_pending;
    assign req_ready = buf_ready && no_pending;
    assign req_fire  = req_valid && req_ready;

    // every request is a single packet so each acceptance unlocks
    assign unlock     = req_fire;
    assign unlock_wid = req.wid;

    assign itr_sel = (req.addr >= itr_ctrl_begin) && (req.addr < itr_ctrl_end);

    csr_data csr_data_i (
        .clk          (clk),
        .reset        (reset),
        .read_addr    (req.addr),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw),
        .write_enable (req_fire && wr_allowed && !itr_sel),
        .write_addr   (req.addr),
        .write_data   (new_value)
    );

    // global hart id per lane
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane_ids
        assign hart_id[i] = (xlen'(core_id) << (nw_bits + nt_bits))
                          + (xlen'(req.wid) << nt_bits)
                          + xlen'(i);
    end

    assign itr_word = req.addr[0] ? xlen'(itr_pending) : xlen'(itr_enable);

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            if (itr_sel) begin
                lane_data[i] = itr_word;
            end else if (req.addr == csr_thread_id) begin
                lane_data[i] = xlen'(i);
            end else if (req.addr == csr_mhartid) begin
                lane_data[i] = hart_id[i];
            end else begin
                lane_data[i] = read_data_ro | read_data_rw;
            end
        end
    end

    // write side
    assign src_value = req.use_imm ? xlen'(req.imm) : req.rs1;
    assign old_value = itr_sel ? itr_word : read_data_rw;

    always_comb begin
        case (req.op)
            csr_rw:  new_value = src_value;
            csr_rs:  new_value = old_value | src_value;
            csr_rc:  new_value = old_value & ~src_value;
            default: new_value = old_value;
        endcase
    end

    // set or clear with nothing to set or clear leaves the CSR alone
    assign wr_allowed = (req.op == csr_rw) || (src_value != '0);

    assign itr_bus.write_enable = req_fire && wr_allowed && itr_sel;
    assign itr_bus.sel_pending  = req.addr[0];
    assign itr_bus.write_data   = new_value;

    // response toward commit
    always_comb begin
        rsp_in.wid   = req.wid;
        rsp_in.tmask = req.tmask;
        rsp_in.pc    = req.pc;
        rsp_in.rd    = req.rd;
        rsp_in.wb    = req.wb;
        rsp_in.data  = lane_data;
    end

    rsp_buffer rsp_buffer_i (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (req_gated),
        .ready_in  (buf_ready),
        .data_in   (rsp_in),
        .valid_out (rsp_valid),
        .data_out  (rsp),
        .ready_out (rsp_ready)
    );

endmodule

/* hw/csr_core_top.sv */
// core level wrapper for the CSR path
// CSR unit plus its interrupt controller

module csr_core_top import csr_pkg::*; (
    input  logic               clk,
    input  logic               reset,

    input  logic               req_valid,
    input  csr_req_t           req,
    output logic               req_ready,
    input  logic               no_pending,
    input  logic [num_irq-1:0] irq_lines,

    output logic               rsp_valid,
    output csr_rsp_t           rsp,
    input  logic               rsp_ready,

    output logic               unlock,
    output logic [nw_bits-1:0] unlock_wid,
    output logic               itr_req
);

    itr_bus_t           itr_bus;
    logic [num_irq-1:0] itr_enable;
    logic [num_irq-1:0] itr_pending;

    csr_unit csr_unit_i (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .no_pending  (no_pending),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .rsp_ready   (rsp_ready),
        .unlock      (unlock),
        .unlock_wid  (unlock_wid),
        .itr_bus     (itr_bus),
        .itr_enable  (itr_enable),
        .itr_pending (itr_pending)
    );

    // one controller per core
    itr_ctrl itr_ctrl_i (
        .clk       (clk),
        .reset     (reset),
        .irq_lines (irq_lines),
        .bus       (itr_bus),
        .enable_q  (itr_enable),
        .pending_q (itr_pending),
        .itr_req   (itr_req)
    );

endmodule

/* sim/csr_chk.sv */
// handshake assertions for the CSR unit
// bound into every csr_unit instance

module csr_chk import csr_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     no_pending,
    input logic     rsp_valid,
    input logic     rsp_ready,
    input csr_rsp_t rsp,
    input logic     unlock
);
    timeunit 1ns;
    timeprecision 1ps;

    // commit side holds its payload while stalled
    rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("rsp dropped or changed while rsp_ready was low");

    // an unlocked request always lands in the response buffer
    unlock_fire: assert property (@(posedge clk) disable iff (reset)
        unlock |=> rsp_valid)
        else $error("unlock without a response entering the buffer");

    // nothing is accepted while the warp still has pending instructions
    ready_gate: assert property (@(posedge clk) disable iff (reset)
        !no_pending && !rsp_valid |=> !rsp_valid)
        else $error("response buffer filled while the warp had pending instructions");

endmodule

bind csr_unit csr_chk chk0 (
    .clk        (clk),
    .reset      (reset),
    .no_pending (no_pending),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .unlock     (unlock)
);

/* sim/csr_tb.sv */
// testbench for the CSR core
// stimulus table, issue and commit processes, closing result line

module csr_tb import csr_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_rows   = 24;
    localparam int wait_limit = 200;

    typedef struct {
        csr_op_e                  op;
        int                       use_imm;
        logic [csr_addr_bits-1:0] addr;
        int                       imm;
        logic [31:0]              rs1;
        int                       wid;
        int                       tmask;
        int                       rd;
        int                       irq;
        logic [31:0]              exp;
        // zero marks an mcycle read
        int                       exp_ok;
        // lane i expects exp plus i
        int                       vary;
        // cycles with no_pending low before the request may go
        int                       hold;
        // itr_req level awaited after acceptance or 2 for none
        int                       itr_wait;
    } row_t;

    logic               clk;
    logic               reset;
    logic               req_valid;
    csr_req_t           req;
    logic               req_ready;
    logic               no_pending;
    logic [num_irq-1:0] irq_lines;
    logic               rsp_valid;
    csr_rsp_t           rsp;
    logic               rsp_ready;
    logic               unlock;
    logic [nw_bits-1:0] unlock_wid;
    logic               itr_req;

    row_t        rows [num_rows];
    int          acc_cycle [num_rows];
    int          exp_q [$];
    int          errors;
    int          checks;
    int          seed;
    int          cycles;
    logic [31:0] last_cycle;

    csr_core_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // clock edges counted since reset released
    always @(posedge clk) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    task automatic load_table();
        // mscratch merge rules
        rows[0]  = '{csr_rw, 0, csr_mscratch, 0, 32'h1234_5678, 0, 'hf, 1, 0, 32'h0, 1, 0, 0, 2};
        rows[1]  = '{csr_rs, 0, csr_mscratch, 0, 32'h0000_00f0, 1, 'hf, 2, 0, 32'h1234_5678,
                     1, 0, 0, 2};
        rows[2]  = '{csr_rc, 1, csr_mscratch, 'h18, 32'h0, 2, 'h3, 3, 0, 32'h1234_56f8,
                     1, 0, 0, 2};
        // zero immediate ignores rs1
        rows[3]  = '{csr_rs, 1, csr_mscratch, 0, 32'hffff_ffff, 3, 'hf, 4, 0, 32'h1234_56e0,
                     1, 0, 0, 2};
        rows[4]  = '{csr_rw, 0, csr_mscratch, 0, 32'h0, 0, 'hf, 5, 0, 32'h1234_56e0, 1, 0, 5, 2};
        // fcsr low byte and read-only ids
        rows[5]  = '{csr_rw, 0, csr_fcsr, 0, 32'h0000_abcd, 1, 'hf, 6, 0, 32'h0, 1, 0, 0, 2};
        rows[6]  = '{csr_rc, 0, csr_fcsr, 0, 32'h0000_000f, 2, 'hf, 7, 0, 32'hcd, 1, 0, 0, 2};
        rows[7]  = '{csr_rw, 0, csr_fcsr, 0, 32'h0, 3, 'hf, 8, 0, 32'hc0, 1, 0, 0, 2};
        rows[8]  = '{csr_rw, 0, csr_mhartid, 0, 32'h0000_ffff, 2, 'hf, 9, 0, 32'h18, 1, 1, 0, 2};
        rows[9]  = '{csr_rs, 0, csr_mhartid, 0, 32'h0, 3, 'hf, 10, 0, 32'h1c, 1, 1, 0, 2};
        rows[10] = '{csr_rs, 1, csr_mhartid, 0, 32'h0, 0, 'h5, 11, 0, 32'h10, 1, 1, 0, 2};
        rows[11] = '{csr_rs, 0, csr_thread_id, 0, 32'h0, 1, 'hf, 12, 0, 32'h0, 1, 1, 0, 2};
        rows[12] = '{csr_rs, 0, csr_mcycle, 0, 32'h0, 0, 'hf, 13, 0, 32'h0, 0, 0, 0, 2};
        rows[13] = '{csr_rs, 0, csr_mcycle, 0, 32'h0, 1, 'hf, 14, 0, 32'h0, 0, 0, 0, 2};
        // interrupt controller with 7c0 enable and 7c1 pending
        rows[14] = '{csr_rs, 0, 12'h7c1, 0, 32'h0, 2, 'hf, 15, 'h4, 32'h4, 1, 0, 0, 2};
        rows[15] = '{csr_rw, 0, 12'h7c0, 0, 32'h4, 3, 'hf, 16, 0, 32'h0, 1, 0, 0, 1};
        rows[16] = '{csr_rc, 0, 12'h7c1, 0, 32'h4, 0, 'hf, 17, 0, 32'h4, 1, 0, 0, 0};
        rows[17] = '{csr_rs, 0, 12'h7c1, 0, 32'h0, 1, 'hf, 18, 0, 32'h0, 1, 0, 0, 2};
        rows[18] = '{csr_rw, 0, 12'h7c0, 0, 32'h0, 2, 'hf, 19, 0, 32'h4, 1, 0, 0, 2};
        // unknown address
        rows[19] = '{csr_rw, 0, 12'h123, 0, 32'h0000_ffff, 3, 'hf, 20, 0, 32'h0, 1, 0, 0, 2};
        rows[20] = '{csr_rs, 0, 12'h123, 0, 32'h0, 0, 'hf, 21, 0, 32'h0, 1, 0, 0, 2};
        // back to back traffic into a stalled commit port
        rows[21] = '{csr_rw, 0, csr_mscratch, 0, 32'ha5a5_0001, 1, 'hf, 22, 0, 32'h0, 1, 0, 0, 2};
        rows[22] = '{csr_rw, 0, csr_mscratch, 0, 32'ha5a5_0002, 2, 'hf, 23, 0, 32'ha5a5_0001,
                     1, 0, 0, 2};
        rows[23] = '{csr_rs, 0, csr_mscratch, 0, 32'h0, 3, 'hf, 24, 0, 32'ha5a5_0002,
                     1, 0, 0, 2};
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // runs from one negedge to the negedge after acceptance
    task automatic issue_row(input int k, output logic ok);
        row_t r;
        int   cnt;
        int   h;
        r  = rows[k];
        ok = 1'b1;
        if (r.irq != 0) begin
            irq_lines = num_irq'(r.irq);
            @(negedge clk);
            irq_lines = '0;
        end
        req.wid     = nw_bits'(r.wid);
        req.tmask   = num_lanes'(r.tmask);
        req.pc      = 32'h0000_1000 + 32'(k * 4);
        req.rd      = 5'(r.rd);
        req.wb      = 1'b1;
        req.op      = r.op;
        req.use_imm = (r.use_imm != 0);
        req.addr    = r.addr;
        req.imm     = 5'(r.imm);
        req.rs1     = r.rs1;
        req_valid   = 1'b1;
        no_pending  = (r.hold == 0);
        for (h = 0; h < r.hold; h++) begin
            #5;
            expect_eq("req_ready", 32'(req_ready), 32'h0);
            expect_eq("unlock", 32'(unlock), 32'h0);
            @(negedge clk);
        end
        no_pending = 1'b1;
        cnt = 0;
        #5;
        while (req_ready !== 1'b1 && cnt < wait_limit) begin
            @(negedge clk);
            #5;
            cnt++;
        end
        if (req_ready !== 1'b1) begin
            $display("timeout: req_ready stayed low for row %0d", k);
            errors++;
            ok = 1'b0;
            return;
        end
        expect_eq("unlock", 32'(unlock), 32'h1);
        expect_eq("unlock_wid", 32'(unlock_wid), 32'(r.wid));
        acc_cycle[k] = cycles;
        exp_q.push_back(k);
        @(negedge clk);
        req_valid = 1'b0;
        if (r.itr_wait != 2) begin
            cnt = 0;
            #5;
            while (int'(itr_req) != r.itr_wait && cnt < wait_limit) begin
                @(negedge clk);
                #5;
                cnt++;
            end
            if (int'(itr_req) != r.itr_wait) begin
                $display("timeout: itr_req never reached %0d after row %0d", r.itr_wait, k);
                errors++;
            end
            @(negedge clk);
        end
    endtask

    task automatic check_rsp(input int k);
        row_t        r;
        logic [31:0] want;
        int          i;
        r = rows[k];
        expect_eq("rsp.wid", 32'(rsp.wid), 32'(r.wid));
        expect_eq("rsp.tmask", 32'(rsp.tmask), 32'(r.tmask));
        expect_eq("rsp.pc", rsp.pc, 32'h0000_1000 + 32'(k * 4));
        expect_eq("rsp.rd", 32'(rsp.rd), 32'(r.rd));
        expect_eq("rsp.wb", 32'(rsp.wb), 32'h1);
        for (i = 0; i < num_lanes; i++) begin
            // mcycle is broadcast and counts edges since reset
            want = (r.exp_ok != 0) ? r.exp + 32'((r.vary != 0) ? i : 0) : 32'(acc_cycle[k]);
            expect_eq($sformatf("rsp.data[%0d]", i), rsp.data[i], want);
        end
        if (r.exp_ok == 0) begin
            checks++;
            if (rsp.data[0] <= last_cycle) begin
                $display("CHECK FAILED t=%0t rsp.data[0]: got %h expected above %h",
                         $time, rsp.data[0], last_cycle);
                errors++;
            end
            last_cycle = rsp.data[0];
        end
    endtask

    // random back-pressure on the commit port
    task automatic collect_all();
        int   n;
        int   cnt;
        logic got;
        for (n = 0; n < num_rows; n++) begin
            got = 1'b0;
            cnt = 0;
            while (!got && cnt < wait_limit) begin
                @(negedge clk);
                rsp_ready = 1'($random(seed));
                #5;
                got = rsp_valid && rsp_ready;
                cnt++;
            end
            if (!got) begin
                $display("timeout: response %0d never arrived at the commit port", n);
                errors++;
                break;
            end
            if (exp_q.size() == 0) begin
                $display("response %0d arrived without an accepted request", n);
                errors++;
                break;
            end
            check_rsp(exp_q.pop_front());
        end
        @(negedge clk);
        rsp_ready = 1'b0;
    endtask

    initial begin
        int   k;
        logic ok;
        seed       = 80;
        errors     = 0;
        checks     = 0;
        last_cycle = '0;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        no_pending = 1'b1;
        irq_lines  = '0;
        rsp_ready  = 1'b0;
        load_table();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        fork
            begin
                for (k = 0; k < num_rows; k++) begin
                    issue_row(k, ok);
                    if (!ok) begin
                        break;
                    end
                end
            end
            collect_all();
        join
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/csr_pkg.sv
hw/csr_data.sv
hw/itr_ctrl.sv
hw/rsp_buffer.sv
hw/csr_unit.sv
hw/csr_core_top.sv
sim/csr_chk.sv
sim/csr_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module csr_tb -f tb.f -o csr_sim

out=$(./obj_dir/csr_sim)
echo "$out"

if grep -qx "RESULT: PASS" <<< "$out"; then
    exit 0
else
    exit 1
fi
